// ==== rtl/periph_pkg.sv ====
/* constants and packed types shared by the peripheral bus, the UART
   and the testbench; modules take them by wildcard import */
`default_nettype none

package periph_pkg;

   localparam int BUS_ADDR_W    = 18;
   localparam int BUS_DATA_W    = 64;
   localparam int BUS_BE_W      = 8;
   localparam int SLOT_LSB      = 15;  // addr[17:15] picks the slot
   localparam int NUM_SLOTS     = 8;
   localparam int UART_SLOT     = 6;
   localparam int UBAUD_DEFAULT = 54;  // clocks per bit
   localparam int BAUD_W        = 16;
   localparam int FIFO_DEPTH    = 16;  // power of two, pointers wrap
   localparam int FIFO_CNT_W    = 5;

   typedef struct packed {
      logic                  en;
      logic [BUS_BE_W-1:0]   be;
      logic [BUS_ADDR_W-1:0] addr;
      logic [BUS_DATA_W-1:0] wdata;
   } bus_req_t;

   typedef struct packed {
      logic       err;   // stop bit sampled low
      logic [7:0] data;
   } rx_entry_t;

   typedef struct packed {
      logic      rx_full;
      logic      tx_full;
      logic      rx_empty;
      rx_entry_t head;   // receive fifo head, no pop
   } uart_status_t;

endpackage

`default_nettype wire

// ==== rtl/payload_fifo.sv ====
/* synchronous first-word-fall-through FIFO, the payload type is a
   parameter and the depth comes from the package */
`timescale 1ns/1ns
`default_nettype none

module payload_fifo import periph_pkg::*;
#(
   parameter type payload_t = logic [7:0]
)
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  logic                  push_i,
   input  logic                  pop_i,
   input  payload_t              wdata_i,
   output payload_t              rdata_o,
   output logic                  full_o,
   output logic                  empty_o,
   output logic [FIFO_CNT_W-1:0] count_o
);

   payload_t              mem [FIFO_DEPTH];
   logic [FIFO_CNT_W-2:0] wr_ptr_q, rd_ptr_q;
   logic [FIFO_CNT_W-1:0] count_q, count_d;
   logic                  do_push, do_pop;

   assign do_push = push_i & ~full_o;   // push when full is ignored
   assign do_pop  = pop_i & ~empty_o;   // same for pop when empty
   assign count_d = count_q + FIFO_CNT_W'(do_push) - FIFO_CNT_W'(do_pop);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         full_o   <= 1'b0;
         empty_o  <= 1'b1;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_d;
         full_o  <= (count_d == FIFO_CNT_W'(FIFO_DEPTH));  // registered flags
         empty_o <= (count_d == '0);
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
         mem[wr_ptr_q] <= wdata_i;
   end

   assign rdata_o = mem[rd_ptr_q];  // head visible without a pop
   assign count_o = count_q;

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
/* UART transmitter, a small sequencer pops the fifo head and a
   baud counter shifts out start, eight data bits lsb first and stop */
`timescale 1ns/1ns
`default_nettype none

module uart_tx import periph_pkg::*;
(
   input  logic              msoc_clk,
   input  logic              rstn,
   input  logic [BAUD_W-1:0] baud_i,
   input  logic              fifo_empty_i,
   input  logic [7:0]        fifo_data_i,
   output logic              fifo_pop_o,
   output logic              tx_o
);

   typedef enum logic [2:0] {TX_IDLE, TX_EMPTY, TX_POP, TX_START, TX_BUSY} tx_state_t;

   tx_state_t         state_q, state_d;
   logic [7:0]        byte_q;
   logic [9:0]        shift_q;
   logic [BAUD_W-1:0] baud_q, baud_cnt_q;
   logic [3:0]        bit_cnt_q;
   logic              bit_end;

   assign bit_end    = (baud_cnt_q == baud_q - 1'b1);
   assign fifo_pop_o = (state_q == TX_POP);
   assign tx_o       = shift_q[0];

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         TX_IDLE:  state_d = TX_EMPTY;
         TX_EMPTY: if (!fifo_empty_i) state_d = TX_POP;
         TX_POP:   state_d = TX_START;
         TX_START: state_d = TX_BUSY;
         TX_BUSY:  if (bit_end && bit_cnt_q == 4'd9) state_d = TX_IDLE;
         default:  state_d = TX_IDLE;
      endcase
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q    <= TX_IDLE;
         shift_q    <= '1;  // line idles high
         baud_q     <= BAUD_W'(UBAUD_DEFAULT);
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == TX_START)
         begin
            shift_q    <= {1'b1, byte_q, 1'b0};  // stop, data, start
            baud_q     <= baud_i;                // baud held for the frame
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
         end
         else if (state_q == TX_BUSY)
         begin
            if (bit_end)
            begin
               baud_cnt_q <= '0;
               shift_q    <= {1'b1, shift_q[9:1]};
               bit_cnt_q  <= bit_cnt_q + 1'b1;
            end
            else
               baud_cnt_q <= baud_cnt_q + 1'b1;
         end
      end
   end

   // head captured as it is popped, loaded one cycle later
   always_ff @(posedge msoc_clk)
   begin
      if (state_q == TX_POP)
         byte_q <= fifo_data_i;
   end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
/* UART receiver behind a three-sample majority filter, samples each bit
   at its middle and returns the byte with a framing error flag */
`timescale 1ns/1ns
`default_nettype none

module uart_rx import periph_pkg::*;
(
   input  logic              msoc_clk,
   input  logic              rstn,
   input  logic [BAUD_W-1:0] baud_i,
   input  logic              rx_i,
   output logic              valid_o,
   output rx_entry_t         entry_o
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t         state_q;
   logic [2:0]        sync_q;
   logic              maj, maj_q;
   logic [BAUD_W-1:0] baud_q, cnt_q;
   logic [2:0]        bit_cnt_q;
   logic [7:0]        data_q;
   logic              half_end, bit_end;

   // two of three samples win
   assign maj = (sync_q[0] & sync_q[1]) | (sync_q[0] & sync_q[2]) | (sync_q[1] & sync_q[2]);

   assign half_end = (cnt_q == (baud_q >> 1));
   assign bit_end  = (cnt_q == baud_q - 1'b1);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         state_q   <= RX_IDLE;
         sync_q    <= '1;
         maj_q     <= 1'b1;
         baud_q    <= BAUD_W'(UBAUD_DEFAULT);
         cnt_q     <= '0;
         bit_cnt_q <= '0;
         valid_o   <= 1'b0;
      end
      else
      begin
         sync_q  <= {sync_q[1:0], rx_i};
         maj_q   <= maj;
         valid_o <= 1'b0;
         case (state_q)
            RX_IDLE:
               if (maj_q && !maj)  // falling start edge
               begin
                  state_q <= RX_START;
                  cnt_q   <= '0;
                  baud_q  <= baud_i;
               end
            RX_START:
               if (half_end)
               begin
                  cnt_q     <= '0;
                  bit_cnt_q <= '0;
                  state_q   <= maj ? RX_IDLE : RX_DATA;  // glitch, not a start bit
               end
               else
                  cnt_q <= cnt_q + 1'b1;
            RX_DATA:
               if (bit_end)
               begin
                  cnt_q     <= '0;
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == 3'd7)
                     state_q <= RX_STOP;
               end
               else
                  cnt_q <= cnt_q + 1'b1;
            RX_STOP:
               if (bit_end)
               begin
                  valid_o <= 1'b1;
                  state_q <= RX_IDLE;
               end
               else
                  cnt_q <= cnt_q + 1'b1;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == RX_DATA && bit_end)
         data_q <= {maj, data_q[7:1]};  // lsb arrives first
      if (state_q == RX_STOP && bit_end)
      begin
         entry_o.err  <= ~maj;
         entry_o.data <= data_q;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/uart_regs.sv ====
/* UART register block in slot 6, decodes pushes, pops and the baud write,
   and assembles the baud, status and fifo count read words */
`timescale 1ns/1ns
`default_nettype none

module uart_regs import periph_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  bus_req_t              req_i,
   output logic [BUS_DATA_W-1:0] rdata_o,
   input  logic                  rx_i,
   output logic                  tx_o,
   output logic                  irq_o
);

   logic                  wr, tx_push, rx_pop, baud_wr;
   logic [BAUD_W-1:0]     baud_q;
   logic                  tx_pop, tx_full, tx_empty;
   logic [7:0]            tx_head;
   logic [FIFO_CNT_W-1:0] tx_count, rx_count;
   logic                  rx_valid, rx_full, rx_empty;
   rx_entry_t             rx_entry, rx_head;
   uart_status_t          status;

   // bit 14 selects the register space, bits 13:12 the action
   assign wr      = req_i.en & (|req_i.be) & req_i.addr[14];
   assign tx_push = wr & (req_i.addr[13:12] == 2'b00);
   assign rx_pop  = wr & (req_i.addr[13:12] == 2'b01);
   assign baud_wr = wr & (req_i.addr[13:12] == 2'b10);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         baud_q <= BAUD_W'(UBAUD_DEFAULT);
      else if (baud_wr)
         baud_q <= req_i.wdata[BAUD_W-1:0];
   end

   assign irq_o = ~rx_empty;  // high while rx data waits

   always_comb
   begin
      status.rx_full  = rx_full;
      status.tx_full  = tx_full;
      status.rx_empty = rx_empty;
      status.head     = rx_head;
      rdata_o = '0;
      if (!req_i.addr[14])
         rdata_o[BAUD_W-1:0] = baud_q;
      else if (!req_i.addr[13])
         rdata_o[$bits(uart_status_t)-1:0] = status;
      else
      begin
         rdata_o[16 +: FIFO_CNT_W] = tx_count;  // tx count at bit 16
         rdata_o[FIFO_CNT_W-1:0]   = rx_count;
      end
   end

   payload_fifo #(.payload_t(logic [7:0])) u_tx_fifo (
      .msoc_clk (msoc_clk), .rstn (rstn),
      .push_i   (tx_push),  .pop_i (tx_pop),
      .wdata_i  (req_i.wdata[7:0]), .rdata_o (tx_head),
      .full_o   (tx_full),  .empty_o (tx_empty), .count_o (tx_count)
   );

   // a full rx fifo drops the new entry
   payload_fifo #(.payload_t(rx_entry_t)) u_rx_fifo (
      .msoc_clk (msoc_clk), .rstn (rstn),
      .push_i   (rx_valid), .pop_i (rx_pop),
      .wdata_i  (rx_entry), .rdata_o (rx_head),
      .full_o   (rx_full),  .empty_o (rx_empty), .count_o (rx_count)
   );

   uart_tx u_tx (
      .msoc_clk (msoc_clk), .rstn (rstn), .baud_i (baud_q),
      .fifo_empty_i (tx_empty), .fifo_data_i (tx_head),
      .fifo_pop_o (tx_pop), .tx_o (tx_o)
   );

   uart_rx u_rx (
      .msoc_clk (msoc_clk), .rstn (rstn), .baud_i (baud_q),
      .rx_i (rx_i), .valid_o (rx_valid), .entry_o (rx_entry)
   );

endmodule

`default_nettype wire

// ==== rtl/periph_top.sv ====
/* peripheral bus top, decodes the slot field of the address and
   ORs the slot read words onto the combinational read port */
`timescale 1ns/1ns
`default_nettype none

module periph_top import periph_pkg::*;
(
   input  logic                  msoc_clk,
   input  logic                  rstn,
   input  bus_req_t              bus_i,
   output logic [BUS_DATA_W-1:0] rdata_o,
   input  logic                  uart_rx_i,
   output logic                  uart_tx_o,
   output logic                  irq_o
);

   logic [NUM_SLOTS-1:0]  slot_hit;
   logic [BUS_DATA_W-1:0] slot_rdata [NUM_SLOTS];
   logic [BUS_DATA_W-1:0] uart_rdata;
   bus_req_t              uart_req;

   always_comb
   begin
      rdata_o = '0;
      for (int i = 0; i < NUM_SLOTS; i++)
      begin
         slot_hit[i] = (bus_i.addr[BUS_ADDR_W-1:SLOT_LSB] == (BUS_ADDR_W-SLOT_LSB)'(i));
         slot_rdata[i] = (i == UART_SLOT) ? uart_rdata : '0;  // empty slots read zero
         rdata_o |= slot_hit[i] ? slot_rdata[i] : '0;
      end
   end

   always_comb
   begin
      uart_req = bus_i;
      uart_req.en = bus_i.en & slot_hit[UART_SLOT];  // qualified by the slot hit
   end

   uart_regs u_uart (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .req_i    (uart_req),
      .rdata_o  (uart_rdata),
      .rx_i     (uart_rx_i),
      .tx_o     (uart_tx_o),
      .irq_o    (irq_o)
   );

endmodule

`default_nettype wire

// ==== tests/periph_asserts.sv ====
/* concurrent checks on the UART register block, attached to every
   uart_regs instance by the bind at the bottom */
`timescale 1ns/1ns
`default_nettype none

module periph_asserts import periph_pkg::*;
(
   input wire                  msoc_clk,
   input wire                  rstn,
   input wire                  irq_i,
   input wire                  tx_i,
   input wire                  tx_empty_i,
   input wire                  rx_empty_i,
   input wire                  tx_pop_i,
   input wire                  rx_pop_i,
   input wire [FIFO_CNT_W-1:0] rx_count_i,
   input wire [2:0]            tx_state_i
);

   int fail_cnt = 0;

   // irq against the occupancy counter rather than the empty flag
   irq_follows_rx: assert property (@(posedge msoc_clk) disable iff (!rstn)
      irq_i == (rx_count_i != '0))
   else
   begin
      fail_cnt++;
      $error("irq differs from rx fifo non-empty");
   end

   // states 0 and 1 are idle and empty-wait
   tx_idle_high: assert property (@(posedge msoc_clk) disable iff (!rstn)
      (tx_empty_i && tx_state_i <= 3'd1) |-> tx_i)
   else
   begin
      fail_cnt++;
      $error("tx line low while idle");
   end

   tx_pop_ok: assert property (@(posedge msoc_clk) disable iff (!rstn)
      tx_pop_i |-> !tx_empty_i)
   else
   begin
      fail_cnt++;
      $error("tx fifo popped while empty");
   end

   rx_pop_ok: assert property (@(posedge msoc_clk) disable iff (!rstn)
      rx_pop_i |-> !rx_empty_i)
   else
   begin
      fail_cnt++;
      $error("rx fifo popped while empty");
   end

endmodule

bind uart_regs periph_asserts u_asserts (
   .msoc_clk (msoc_clk), .rstn (rstn), .irq_i (irq_o), .tx_i (tx_o),
   .tx_empty_i (tx_empty), .rx_empty_i (rx_empty), .tx_pop_i (tx_pop),
   .rx_pop_i (rx_pop), .rx_count_i (rx_count), .tx_state_i (u_tx.state_q)
);

`default_nettype wire

// ==== tests/periph_tb.sv ====
/* testbench for the peripheral bus UART, loops the transmit line back to
   the receiver and plays the vectors from tests/uart_vectors.mem */
`timescale 1ns/1ns
`default_nettype none

module periph_tb import periph_pkg::*;;

   localparam int NUM_VEC   = 12;
   localparam int BURST     = 4;
   localparam int FLOOD     = 18;
   localparam int FAST_BAUD = 12;
   localparam logic [BUS_ADDR_W-1:0] UART_BASE = BUS_ADDR_W'(UART_SLOT) << SLOT_LSB;

   logic                  msoc_clk;
   logic                  rstn;
   bus_req_t              bus;
   logic [BUS_DATA_W-1:0] rdata;
   logic                  uart_tx, uart_rx, irq;
   logic                  bad_on, bad_line;
   logic [31:0]           vec [NUM_VEC];  // baud, byte, corrupt flag
   logic [15:0]           lfsr_q;
   longint                limit_ns;
   int                    errors;

   assign uart_rx = bad_on ? bad_line : uart_tx;  // loopback unless a bad frame is driven

   periph_top UUT (
      .msoc_clk (msoc_clk), .rstn (rstn), .bus_i (bus), .rdata_o (rdata),
      .uart_rx_i (uart_rx), .uart_tx_o (uart_tx), .irq_o (irq)
   );

   always #4 msoc_clk = ~msoc_clk;

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   function automatic logic [63:0] status_word(input logic full, input logic tfull,
                                                input logic empty, input logic err,
                                                input logic [7:0] data);
      return 64'({full, tfull, empty, err, data});  // layout of the status read
   endfunction

   function automatic logic [63:0] count_word(input int tx, input int rx);
      return (64'(tx) << 16) | 64'(rx);
   endfunction

   // galois lfsr stepped once per bit taken
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic rand_byte(output logic [7:0] b);
      for (int i = 0; i < 8; i++)
      begin
         b[i]   = lfsr_q[0];
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [63:0] data);
      @(negedge msoc_clk);
      bus = '{en: 1'b1, be: '1, addr: addr, wdata: data};
      @(negedge msoc_clk);
      bus = '0;
   endtask

   task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output logic [63:0] data);
      @(negedge msoc_clk);
      bus = '{en: 1'b1, be: '0, addr: addr, wdata: '0};
      #2 data = rdata;  // settled before the rising edge
   endtask

   task automatic wait_irq(input int max_cycles);
      int n;
      n = 0;
      while (!irq && n < max_cycles)
      begin
         @(negedge msoc_clk);
         n++;
      end
      if (!irq)
      begin
         $display("interrupt never rose after a byte was sent");
         errors++;
      end
   endtask

   // polls the counts word until the chosen count reaches want
   task automatic wait_count(input bit tx_side, input int want, input int max_cycles);
      logic [63:0] d;
      int n;
      n = 0;
      bus_read(UART_BASE | 18'h6000, d);
      while ((tx_side ? int'(d[20:16]) : int'(d[4:0])) != want && n < max_cycles)
      begin
         bus_read(UART_BASE | 18'h6000, d);
         n++;
      end
      if (n >= max_cycles)
      begin
         $display("fifo count did not reach %0d in time", want);
         errors++;
      end
   endtask

   task automatic drive_bad_frame(input int baud, input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b0, b, 1'b0};  // stop bit forced low
      @(negedge msoc_clk);
      bad_on = 1'b1;
      for (int i = 0; i < 10; i++)
      begin
         bad_line = frame[i];
         repeat (baud) @(negedge msoc_clk);
      end
      bad_line = 1'b1;
      repeat (2 * baud) @(negedge msoc_clk);
      bad_on = 1'b0;
   endtask

   task automatic pop_expect(input logic [7:0] b, input logic err);
      logic [63:0] d;
      bus_read(UART_BASE | 18'h4000, d);
      check("status", d & 64'h1FF, 64'({err, b}));
      bus_write(UART_BASE | 18'h5000, 64'h0);
   endtask

   initial
   begin
      wait (limit_ns != 0);
      #(limit_ns);
      $display("watchdog expired after %0d ns, run stopped", limit_ns);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      logic [63:0] d;
      logic [7:0]  b;
      logic [7:0]  sent [$];
      int          baud, max_baud;
      int          asrt_fails;
      msoc_clk = 1'b0;
      rstn     = 1'b0;
      bus      = '0;
      bad_on   = 1'b0;
      bad_line = 1'b1;
      errors   = 0;
      lfsr_q   = 16'd18095;
      limit_ns = 0;
      $readmemh("tests/uart_vectors.mem", vec);
      max_baud = FAST_BAUD;
      foreach (vec[i])
         if (int'(vec[i][31:16]) > max_baud)
            max_baud = int'(vec[i][31:16]);
      limit_ns = longint'(NUM_VEC + BURST + 1 + FLOOD) * 12 * 10 * max_baud * 8 + 20000;
      repeat (3) @(negedge msoc_clk);
      rstn = 1'b1;

      @(negedge msoc_clk);
      check("irq_o", 64'(irq), 64'h0);
      check("uart_tx_o", 64'(uart_tx), 64'h1);
      bus_read(UART_BASE, d);
      check("baud", d, 64'(UBAUD_DEFAULT));
      bus_read(UART_BASE | 18'h4000, d);
      check("status", d & 64'hE00, status_word(1'b0, 1'b0, 1'b1, 1'b0, 8'h00));
      bus_read(UART_BASE | 18'h6000, d);
      check("counts", d, count_word(0, 0));
      bus_read(18'h04000, d);
      check("slot0", d, 64'h0);

      foreach (vec[i])
      begin
         baud = int'(vec[i][31:16]);
         b    = vec[i][15:8];
         bus_write(UART_BASE | 18'h6000, 64'(baud));
         if (vec[i][0])
            drive_bad_frame(baud, b);
         else
            bus_write(UART_BASE | 18'h4000, 64'(b));
         wait_irq(14 * baud + 20);
         pop_expect(b, vec[i][0]);
         bus_read(UART_BASE | 18'h4000, d);
         check("irq_o", 64'(irq), 64'h0);
         check("status", d & 64'hE00, status_word(1'b0, 1'b0, 1'b1, 1'b0, 8'h00));
      end

      // the leading byte keeps the transmitter busy during the burst
      bus_write(UART_BASE | 18'h6000, 64'(FAST_BAUD));
      rand_byte(b);
      sent.push_back(b);
      bus_write(UART_BASE | 18'h4000, 64'(b));
      repeat (8) @(negedge msoc_clk);
      for (int i = 0; i < BURST; i++)
      begin
         rand_byte(b);
         sent.push_back(b);
         bus_write(UART_BASE | 18'h4000, 64'(b));
      end
      bus_read(UART_BASE | 18'h6000, d);
      check("tx_count", 64'(d[20:16]), 64'(BURST));
      wait_count(1'b0, BURST + 1, 14 * FAST_BAUD * (BURST + 2));
      bus_read(UART_BASE | 18'h6000, d);
      check("rx_count", 64'(d[4:0]), 64'(BURST + 1));
      while (sent.size() > 0)
         pop_expect(sent.pop_front(), 1'b0);

      // receive fifo overflow sent in two chunks
      for (int c = 0; c < 2; c++)
      begin
         for (int i = 0; i < FLOOD / 2; i++)
         begin
            rand_byte(b);
            sent.push_back(b);
            bus_write(UART_BASE | 18'h4000, 64'(b));
         end
         wait_count(1'b1, 0, 14 * FAST_BAUD * FLOOD);
      end
      repeat (12 * FAST_BAUD) @(negedge msoc_clk);  // last frame lands and is dropped
      bus_read(UART_BASE | 18'h6000, d);
      check("rx_count", 64'(d[4:0]), 64'(FIFO_DEPTH));
      bus_read(UART_BASE | 18'h4000, d);
      check("rx_full", 64'(d[11]), 64'h1);
      for (int i = 0; i < FIFO_DEPTH; i++)
         pop_expect(sent[i], 1'b0);
      bus_read(UART_BASE | 18'h6000, d);
      check("counts", d, count_word(0, 0));
      check("irq_o", 64'(irq), 64'h0);

      asrt_fails = UUT.u_uart.u_asserts.fail_cnt;
      $display("errors: %0d, assertion failures: %0d", errors, asrt_fails);
      if (errors == 0 && asrt_fails == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/uart_vectors.mem ====
// columns: baud (clocks per bit, 4 hex digits), byte, corrupt stop bit flag
// a set flag makes the testbench drive the frame with a low stop bit
0010_41_00
0008_5A_00
0020_00_00
0018_FF_00
000C_C3_01
0028_7E_00
0010_A5_00
0014_3C_01
0036_81_00
000A_55_00
0030_E7_01
0012_0F_00

// ==== verilog.f ====
rtl/periph_pkg.sv
rtl/payload_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/periph_top.sv
tests/periph_asserts.sv
tests/periph_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass message in the log
set -e
cd "$(dirname "$0")"

verilator --binary --top-module periph_tb -f verilog.f -o periph_sim

./obj_dir/periph_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
   exit 0
fi
exit 1
